/* Makefile */
TOP = bm_dma_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* design/bm_dma_top.sv */
// Bus-master ADC DMA endpoint top level joining the register block, address FIFOs and writer
`timescale 1ns/100ps

module bm_dma_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  dma_cfg_pkg::reg_addr_t   s_awaddr_i,
    input  logic                     s_awvalid_i,
    output logic                     s_awready_o,
    input  dma_data_pkg::word_t      s_wdata_i,
    input  logic                     s_wvalid_i,
    output logic                     s_wready_o,
    output logic [1:0]               s_bresp_o,
    output logic                     s_bvalid_o,
    input  logic                     s_bready_i,
    input  dma_cfg_pkg::reg_addr_t   s_araddr_i,
    input  logic                     s_arvalid_i,
    output logic                     s_arready_o,
    output dma_data_pkg::word_t      s_rdata_o,
    output logic [1:0]               s_rresp_o,
    output logic                     s_rvalid_o,
    input  logic                     s_rready_i,
    input  dma_data_pkg::sample_t    adc1_i,
    input  dma_data_pkg::sample_t    adc2_i,
    input  logic                     sample_valid_i,
    output logic                     sample_ready_o,
    output dma_data_pkg::byte_addr_t wr_addr_o,
    output dma_data_pkg::word_t      wr_data_o,
    output logic                     wr_valid_o,
    input  logic                     wr_ready_i
);

    logic                      enable;
    logic                      soft_rst;
    dma_data_pkg::buf_len_t    buf_len;
    // --------------------------------------------------
    // Free FIFO, host to writer
    // --------------------------------------------------
    logic                      post_push;
    dma_data_pkg::byte_addr_t  post_addr;
    logic                      free_pop;
    dma_data_pkg::byte_addr_t  free_head;
    logic                      free_empty;
    logic                      free_full;
    dma_data_pkg::fifo_level_t free_level;
    // --------------------------------------------------
    // Return FIFO, writer to host
    // --------------------------------------------------
    logic                      ret_push;
    dma_data_pkg::byte_addr_t  ret_addr;
    logic                      ret_pop;
    dma_data_pkg::byte_addr_t  ret_head;
    logic                      ret_empty;
    logic                      ret_full;
    dma_data_pkg::fifo_level_t ret_level;
    logic                      buf_done;

    dma_ctrl_regs ctrl_regs_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .s_awaddr_i   (s_awaddr_i),
        .s_awvalid_i  (s_awvalid_i),
        .s_awready_o  (s_awready_o),
        .s_wdata_i    (s_wdata_i),
        .s_wvalid_i   (s_wvalid_i),
        .s_wready_o   (s_wready_o),
        .s_bresp_o    (s_bresp_o),
        .s_bvalid_o   (s_bvalid_o),
        .s_bready_i   (s_bready_i),
        .s_araddr_i   (s_araddr_i),
        .s_arvalid_i  (s_arvalid_i),
        .s_arready_o  (s_arready_o),
        .s_rdata_o    (s_rdata_o),
        .s_rresp_o    (s_rresp_o),
        .s_rvalid_o   (s_rvalid_o),
        .s_rready_i   (s_rready_i),
        .enable_o     (enable),
        .soft_rst_o   (soft_rst),
        .buf_len_o    (buf_len),
        .post_push_o  (post_push),
        .post_addr_o  (post_addr),
        .free_full_i  (free_full),
        .free_level_i (free_level),
        .ret_pop_o    (ret_pop),
        .ret_head_i   (ret_head),
        .ret_empty_i  (ret_empty),
        .ret_level_i  (ret_level),
        .buf_done_i   (buf_done)
    );

    buf_addr_fifo free_fifo_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .clear_i     (soft_rst),
        .push_i      (post_push),
        .push_data_i (post_addr),
        .pop_i       (free_pop),
        .head_o      (free_head),
        .empty_o     (free_empty),
        .full_o      (free_full),
        .level_o     (free_level)
    );

    buf_addr_fifo ret_fifo_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .clear_i     (soft_rst),
        .push_i      (ret_push),
        .push_data_i (ret_addr),
        .pop_i       (ret_pop),
        .head_o      (ret_head),
        .empty_o     (ret_empty),
        .full_o      (ret_full),
        .level_o     (ret_level)
    );

    sample_writer writer_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .clear_i        (soft_rst),
        .enable_i       (enable),
        .buf_len_i      (buf_len),
        .free_empty_i   (free_empty),
        .free_head_i    (free_head),
        .free_pop_o     (free_pop),
        .ret_full_i     (ret_full),
        .ret_push_o     (ret_push),
        .ret_addr_o     (ret_addr),
        .buf_done_o     (buf_done),
        .adc1_i         (adc1_i),
        .adc2_i         (adc2_i),
        .sample_valid_i (sample_valid_i),
        .sample_ready_o (sample_ready_o),
        .wr_addr_o      (wr_addr_o),
        .wr_data_o      (wr_data_o),
        .wr_valid_o     (wr_valid_o),
        .wr_ready_i     (wr_ready_i)
    );

endmodule

/* design/buf_addr_fifo.sv */
// Show-ahead FIFO of host buffer addresses, instantiated once for free and once for returned buffers
`timescale 1ns/100ps

module buf_addr_fifo #(
    parameter int DEPTH = dma_data_pkg::ADDR_FIFO_DEPTH
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      clear_i,
    input  logic                      push_i,
    input  dma_data_pkg::byte_addr_t  push_data_i,
    input  logic                      pop_i,
    output dma_data_pkg::byte_addr_t  head_o,
    output logic                      empty_o,
    output logic                      full_o,
    output dma_data_pkg::fifo_level_t level_o
);

    localparam int PTR_W = $clog2(DEPTH);

    dma_data_pkg::byte_addr_t  mem [DEPTH];
    logic [PTR_W-1:0]          wr_ptr;
    logic [PTR_W-1:0]          rd_ptr;
    dma_data_pkg::fifo_level_t level;
    logic                      do_push;
    logic                      do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty_o = (level == '0);
    assign full_o  = (level == dma_data_pkg::fifo_level_t'(DEPTH));
    assign level_o = level;
    assign head_o  = mem[rd_ptr];  // Valid whenever not empty

    assign do_push = push_i && !full_o;   // Push on full is dropped
    assign do_pop  = pop_i && !empty_o;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || clear_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (do_push && !do_pop) begin
                level <= level + 1'b1;
            end else if (do_pop && !do_push) begin
                level <= level - 1'b1;
            end
        end
    end

endmodule

/* design/dma_cfg_pkg.sv */
// Register offsets, control bits and bus response codes for the DMA control register block
package dma_cfg_pkg;

    // --------------------------------------------------
    // Register map
    // --------------------------------------------------
    typedef logic [7:0] reg_addr_t;

    localparam reg_addr_t REG_CTRL       = 8'h00;  // Enable and soft reset
    localparam reg_addr_t REG_BUF_LEN    = 8'h04;  // Words per buffer
    localparam reg_addr_t REG_BUF_POST   = 8'h08;  // Push into free FIFO
    localparam reg_addr_t REG_BUF_RETURN = 8'h0C;  // Pop from return FIFO
    localparam reg_addr_t REG_STATUS     = 8'h10;  // Levels and overflow
    localparam reg_addr_t REG_BUF_DONE   = 8'h14;  // Completed buffers

    // --------------------------------------------------
    // Bit positions
    // --------------------------------------------------
    localparam int CTRL_ENABLE_BIT     = 0;
    localparam int CTRL_SOFT_RST_BIT   = 1;   // Self-clearing
    localparam int STATUS_OVERFLOW_BIT = 16;  // Sticky

    // AXI4-Lite responses
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

/* design/dma_ctrl_regs.sv */
// AXI4-Lite register block that posts and returns buffer addresses and steers the sample writer
`timescale 1ns/100ps

module dma_ctrl_regs (
    input  logic                      clk,
    input  logic                      rst_n,
    // AXI4-Lite slave
    input  dma_cfg_pkg::reg_addr_t    s_awaddr_i,
    input  logic                      s_awvalid_i,
    output logic                      s_awready_o,
    input  dma_data_pkg::word_t       s_wdata_i,
    input  logic                      s_wvalid_i,
    output logic                      s_wready_o,
    output logic [1:0]                s_bresp_o,
    output logic                      s_bvalid_o,
    input  logic                      s_bready_i,
    input  dma_cfg_pkg::reg_addr_t    s_araddr_i,
    input  logic                      s_arvalid_i,
    output logic                      s_arready_o,
    output dma_data_pkg::word_t       s_rdata_o,
    output logic [1:0]                s_rresp_o,
    output logic                      s_rvalid_o,
    input  logic                      s_rready_i,
    // Steering
    output logic                      enable_o,
    output logic                      soft_rst_o,
    output dma_data_pkg::buf_len_t    buf_len_o,
    output logic                      post_push_o,
    output dma_data_pkg::byte_addr_t  post_addr_o,
    input  logic                      free_full_i,
    input  dma_data_pkg::fifo_level_t free_level_i,
    output logic                      ret_pop_o,
    input  dma_data_pkg::byte_addr_t  ret_head_i,
    input  logic                      ret_empty_i,
    input  dma_data_pkg::fifo_level_t ret_level_i,
    input  logic                      buf_done_i
);

    logic                   wr_fire;
    logic                   rd_fire;
    logic                   post_sel;
    logic                   overflow;
    dma_data_pkg::count_t   done_cnt;
    dma_data_pkg::word_t    status_word;
    dma_data_pkg::word_t    rd_word;
    logic                   rd_err;

    // --------------------------------------------------
    // Handshakes
    // --------------------------------------------------
    assign s_awready_o = !s_bvalid_o;
    assign s_wready_o  = !s_bvalid_o;
    assign s_arready_o = !s_rvalid_o;

    assign wr_fire = s_awvalid_i && s_wvalid_i && !s_bvalid_o;  // AW and W taken together
    assign rd_fire = s_arvalid_i && !s_rvalid_o;

    assign post_sel    = wr_fire && (s_awaddr_i == dma_cfg_pkg::REG_BUF_POST);
    assign post_push_o = post_sel && !free_full_i;
    assign post_addr_o = s_wdata_i;
    assign ret_pop_o   = rd_fire && (s_araddr_i == dma_cfg_pkg::REG_BUF_RETURN) && !ret_empty_i;

    // Control state and B/R valid flags
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            enable_o   <= 1'b0;
            soft_rst_o <= 1'b0;
            buf_len_o  <= '0;
            overflow   <= 1'b0;
            done_cnt   <= '0;
            s_bvalid_o <= 1'b0;
            s_rvalid_o <= 1'b0;
        end else begin
            soft_rst_o <= 1'b0;  // Pulse for one cycle
            if (wr_fire && s_awaddr_i == dma_cfg_pkg::REG_CTRL) begin
                enable_o   <= s_wdata_i[dma_cfg_pkg::CTRL_ENABLE_BIT];
                soft_rst_o <= s_wdata_i[dma_cfg_pkg::CTRL_SOFT_RST_BIT];
            end
            if (wr_fire && s_awaddr_i == dma_cfg_pkg::REG_BUF_LEN) begin
                buf_len_o <= s_wdata_i[7:0];
            end
            if (soft_rst_o) begin
                overflow <= 1'b0;
                done_cnt <= '0;
            end else begin
                if (post_sel && free_full_i) begin
                    overflow <= 1'b1;  // Address dropped
                end
                if (buf_done_i) begin
                    done_cnt <= done_cnt + 1'b1;
                end
            end
            if (wr_fire) begin
                s_bvalid_o <= 1'b1;
            end else if (s_bready_i) begin
                s_bvalid_o <= 1'b0;
            end
            if (rd_fire) begin
                s_rvalid_o <= 1'b1;
            end else if (s_rready_i) begin
                s_rvalid_o <= 1'b0;
            end
        end
    end

    // --------------------------------------------------
    // Read decode
    // --------------------------------------------------
    always_comb begin
        status_word = '0;
        status_word[4:0]  = free_level_i;
        status_word[12:8] = ret_level_i;
        status_word[dma_cfg_pkg::STATUS_OVERFLOW_BIT] = overflow;
    end

    always_comb begin
        rd_word = '0;
        rd_err  = 1'b0;
        case (s_araddr_i)
            dma_cfg_pkg::REG_CTRL:       rd_word[dma_cfg_pkg::CTRL_ENABLE_BIT] = enable_o;
            dma_cfg_pkg::REG_BUF_LEN:    rd_word[7:0] = buf_len_o;
            dma_cfg_pkg::REG_BUF_RETURN: begin
                rd_word = ret_empty_i ? '0 : ret_head_i;
                rd_err  = ret_empty_i;  // Nothing to hand back
            end
            dma_cfg_pkg::REG_STATUS:     rd_word = status_word;
            dma_cfg_pkg::REG_BUF_DONE:   rd_word[15:0] = done_cnt;
            default:                     rd_word = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            s_bresp_o <= (post_sel && free_full_i) ? dma_cfg_pkg::RESP_SLVERR
                                                   : dma_cfg_pkg::RESP_OKAY;
        end
        if (rd_fire) begin
            s_rdata_o <= rd_word;
            s_rresp_o <= rd_err ? dma_cfg_pkg::RESP_SLVERR : dma_cfg_pkg::RESP_OKAY;
        end
    end

endmodule

/* design/dma_data_pkg.sv */
// Data path types and FIFO sizing shared by the sample writer, address FIFOs and register block
package dma_data_pkg;

    // --------------------------------------------------
    // Payload widths
    // --------------------------------------------------
    typedef logic [11:0] sample_t;      // One ADC conversion
    typedef logic [31:0] word_t;        // Host data word and register data
    typedef logic [31:0] byte_addr_t;   // Host byte address
    typedef logic [7:0]  buf_len_t;     // Words per buffer, 0 acts as 1
    typedef logic [15:0] count_t;       // Completed buffer count

    // --------------------------------------------------
    // Buffer address FIFOs
    // --------------------------------------------------
    localparam int ADDR_FIFO_DEPTH = 16;

    typedef logic [4:0] fifo_level_t;   // Holds 0 to ADDR_FIFO_DEPTH

    // Writer sequencing
    typedef enum logic [1:0] {
        IDLE,
        FILL,
        RETIRE
    } writer_state_t;

endpackage

/* design/sample_writer.sv */
// Fills one host buffer at a time with packed ADC sample pairs and hands back its address
`timescale 1ns/100ps

module sample_writer (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     clear_i,
    input  logic                     enable_i,
    input  dma_data_pkg::buf_len_t   buf_len_i,
    input  logic                     free_empty_i,
    input  dma_data_pkg::byte_addr_t free_head_i,
    output logic                     free_pop_o,
    input  logic                     ret_full_i,
    output logic                     ret_push_o,
    output dma_data_pkg::byte_addr_t ret_addr_o,
    output logic                     buf_done_o,
    input  dma_data_pkg::sample_t    adc1_i,
    input  dma_data_pkg::sample_t    adc2_i,
    input  logic                     sample_valid_i,
    output logic                     sample_ready_o,
    output dma_data_pkg::byte_addr_t wr_addr_o,
    output dma_data_pkg::word_t      wr_data_o,
    output logic                     wr_valid_o,
    input  logic                     wr_ready_i
);

    dma_data_pkg::writer_state_t state;
    dma_data_pkg::byte_addr_t    base_addr;
    dma_data_pkg::buf_len_t      word_idx;
    dma_data_pkg::buf_len_t      last_idx;
    logic                        take;

    assign last_idx = (buf_len_i == '0) ? '0 : buf_len_i - 1'b1;  // Zero length acts as one

    // --------------------------------------------------
    // Handshakes
    // --------------------------------------------------
    assign free_pop_o     = (state == dma_data_pkg::IDLE) && enable_i && !free_empty_i;
    assign sample_ready_o = (state == dma_data_pkg::FILL) && (!wr_valid_o || wr_ready_i);
    assign take           = sample_ready_o && sample_valid_i;
    assign ret_push_o     = (state == dma_data_pkg::RETIRE) && !wr_valid_o && !ret_full_i;
    assign ret_addr_o     = base_addr;
    assign buf_done_o     = ret_push_o;  // One cycle, state leaves RETIRE

    always_ff @(posedge clk) begin
        if (!rst_n || clear_i) begin
            state      <= dma_data_pkg::IDLE;
            word_idx   <= '0;
            wr_valid_o <= 1'b0;
        end else begin
            if (take) begin
                wr_valid_o <= 1'b1;
            end else if (wr_ready_i) begin
                wr_valid_o <= 1'b0;
            end
            case (state)
                dma_data_pkg::IDLE: begin
                    word_idx <= '0;
                    if (free_pop_o) begin
                        state <= dma_data_pkg::FILL;
                    end
                end
                dma_data_pkg::FILL: begin
                    if (take) begin
                        word_idx <= word_idx + 1'b1;
                        if (word_idx == last_idx) begin
                            state <= dma_data_pkg::RETIRE;  // Wait for last word to drain
                        end
                    end
                end
                dma_data_pkg::RETIRE: begin
                    if (ret_push_o) begin
                        state <= dma_data_pkg::IDLE;
                    end
                end
                default: state <= dma_data_pkg::IDLE;
            endcase
        end
    end

    // Base address and output word
    always_ff @(posedge clk) begin
        if (free_pop_o) begin
            base_addr <= free_head_i;
        end
        if (take) begin
            wr_addr_o <= base_addr + {22'b0, word_idx, 2'b00};
            wr_data_o <= {4'b0, adc2_i, 4'b0, adc1_i};  // Ch2 at 27:16, ch1 at 11:0
        end
    end

endmodule

/* flist.f */
design/dma_cfg_pkg.sv
design/dma_data_pkg.sv
design/buf_addr_fifo.sv
design/dma_ctrl_regs.sv
design/sample_writer.sv
design/bm_dma_top.sv
tb/bm_dma_assert.sv
tb/bm_dma_tb.sv

/* tb/bm_dma_assert.sv */
// Concurrent checks on the bus handshakes and free FIFO use, bound into the DMA top level
`timescale 1ns/100ps

module bm_dma_assert (
    input logic                      clk,
    input logic                      rst_n,
    input logic                      soft_rst_i,
    input logic                      wr_valid_i,
    input logic                      wr_ready_i,
    input dma_data_pkg::byte_addr_t  wr_addr_i,
    input dma_data_pkg::word_t       wr_data_i,
    input logic                      bvalid_i,
    input logic                      bready_i,
    input logic                      rvalid_i,
    input logic                      rready_i,
    input logic                      free_pop_i,
    input logic                      post_push_i,
    input dma_data_pkg::fifo_level_t free_level_i
);

    // Soft reset may drop a pending word
    assert property (@(posedge clk) disable iff (!rst_n || soft_rst_i)
        wr_valid_i && !wr_ready_i |=> wr_valid_i && $stable(wr_addr_i) && $stable(wr_data_i))
        else $error("write port dropped or changed a pending word");

    assert property (@(posedge clk) disable iff (!rst_n)
        bvalid_i && !bready_i |=> bvalid_i)
        else $error("bvalid fell before bready");

    assert property (@(posedge clk) disable iff (!rst_n)
        rvalid_i && !rready_i |=> rvalid_i)
        else $error("rvalid fell before rready");

    // A pop of an empty FIFO would leave the level unchanged
    assert property (@(posedge clk) disable iff (!rst_n || soft_rst_i)
        free_pop_i && !post_push_i |=> free_level_i == $past(free_level_i) - 1'b1)
        else $error("writer pop did not remove one address from the free FIFO");

endmodule

bind bm_dma_top bm_dma_assert bm_dma_assert_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .soft_rst_i   (soft_rst),
    .wr_valid_i   (wr_valid_o),
    .wr_ready_i   (wr_ready_i),
    .wr_addr_i    (wr_addr_o),
    .wr_data_i    (wr_data_o),
    .bvalid_i     (s_bvalid_o),
    .bready_i     (s_bready_i),
    .rvalid_i     (s_rvalid_o),
    .rready_i     (s_rready_i),
    .free_pop_i   (free_pop),
    .post_push_i  (post_push),
    .free_level_i (free_level)
);

/* tb/bm_dma_tb.sv */
// Testbench for the ADC DMA endpoint that drives registers and samples and checks every host write
`timescale 1ns/100ps

module bm_dma_tb;

    localparam int NUM_BUFS       = 4;
    localparam int BUF_WORDS      = 6;
    localparam int TIMEOUT_CYCLES = 20000;  // Whole run needs well under 2000 cycles

    logic                     clk = 1'b0;
    logic                     rst_n;
    dma_cfg_pkg::reg_addr_t   s_awaddr_i;
    logic                     s_awvalid_i;
    logic                     s_awready_o;
    dma_data_pkg::word_t      s_wdata_i;
    logic                     s_wvalid_i;
    logic                     s_wready_o;
    logic [1:0]               s_bresp_o;
    logic                     s_bvalid_o;
    logic                     s_bready_i;
    dma_cfg_pkg::reg_addr_t   s_araddr_i;
    logic                     s_arvalid_i;
    logic                     s_arready_o;
    dma_data_pkg::word_t      s_rdata_o;
    logic [1:0]               s_rresp_o;
    logic                     s_rvalid_o;
    logic                     s_rready_i;
    dma_data_pkg::sample_t    adc1_i;
    dma_data_pkg::sample_t    adc2_i;
    logic                     sample_valid_i;
    logic                     sample_ready_o;
    dma_data_pkg::byte_addr_t wr_addr_o;
    dma_data_pkg::word_t      wr_data_o;
    logic                     wr_valid_o;
    logic                     wr_ready_i = 1'b0;
    int unsigned              cycle_count = 0;
    dma_data_pkg::byte_addr_t posted [NUM_BUFS];
    dma_data_pkg::byte_addr_t exp_addr_q [$];
    dma_data_pkg::word_t      exp_data_q [$];

    bm_dma_top bm_dma_top_inst (.*);

    always #4 clk = ~clk;  // 8 ns period

    // --------------------------------------------------
    // Reference model and compare tasks
    // --------------------------------------------------
    function automatic void expected_word(input dma_data_pkg::byte_addr_t base,
                                          input int index,
                                          input dma_data_pkg::sample_t adc1,
                                          input dma_data_pkg::sample_t adc2,
                                          output dma_data_pkg::byte_addr_t addr,
                                          output dma_data_pkg::word_t data);
        addr        = base + dma_data_pkg::byte_addr_t'(index * 4);  // Word i at base plus 4i
        data        = '0;
        data[11:0]  = adc1;
        data[27:16] = adc2;
    endfunction

    task automatic abort_run(input string why);
        $display("Something failed");
        $fatal(1, "%s", why);
    endtask

    task automatic check_word(input string name, input dma_data_pkg::word_t got,
                              input dma_data_pkg::word_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
            abort_run("data word mismatch");
        end
    endtask

    task automatic check_addr(input string name, input dma_data_pkg::byte_addr_t got,
                              input dma_data_pkg::byte_addr_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
            abort_run("byte address mismatch");
        end
    endtask

    task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
            abort_run("bus response mismatch");
        end
    endtask

    task automatic check_count(input string name, input dma_data_pkg::count_t got,
                               input dma_data_pkg::count_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
            abort_run("buffer count mismatch");
        end
    endtask

    // --------------------------------------------------
    // AXI4-Lite access, entered and left on a rising edge
    // --------------------------------------------------
    task automatic write_reg(input dma_cfg_pkg::reg_addr_t addr, input dma_data_pkg::word_t data,
                             output logic [1:0] resp);
        s_awaddr_i  <= addr;
        s_awvalid_i <= 1'b1;
        s_wdata_i   <= data;
        s_wvalid_i  <= 1'b1;
        do @(negedge clk); while (!s_awready_o);
        if (!s_wready_o) begin
            abort_run("wready was low while awready was high");
        end
        @(posedge clk);  // AW and W taken
        s_awvalid_i <= 1'b0;
        s_wvalid_i  <= 1'b0;
        repeat ($urandom_range(0, 2)) @(posedge clk);  // Let bvalid wait a little
        s_bready_i <= 1'b1;
        do @(negedge clk); while (!s_bvalid_o);
        resp = s_bresp_o;
        @(posedge clk);
        s_bready_i <= 1'b0;
    endtask

    task automatic read_reg(input dma_cfg_pkg::reg_addr_t addr, output dma_data_pkg::word_t data,
                            output logic [1:0] resp);
        s_araddr_i  <= addr;
        s_arvalid_i <= 1'b1;
        do @(negedge clk); while (!s_arready_o);
        @(posedge clk);
        s_arvalid_i <= 1'b0;
        repeat ($urandom_range(0, 2)) @(posedge clk);
        s_rready_i <= 1'b1;
        do @(negedge clk); while (!s_rvalid_o);
        data = s_rdata_o;
        resp = s_rresp_o;
        @(posedge clk);
        s_rready_i <= 1'b0;
    endtask

    task automatic store_ok(input dma_cfg_pkg::reg_addr_t addr, input dma_data_pkg::word_t data,
                            input string name);
        logic [1:0] resp;
        write_reg(addr, data, resp);
        check_resp({name, "_bresp"}, resp, dma_cfg_pkg::RESP_OKAY);
    endtask

    task automatic expect_read(input dma_cfg_pkg::reg_addr_t addr, input dma_data_pkg::word_t exp,
                               input logic [1:0] exp_resp, input string name);
        dma_data_pkg::word_t data;
        logic [1:0]          resp;
        read_reg(addr, data, resp);
        check_word(name, data, exp);
        check_resp({name, "_rresp"}, resp, exp_resp);
    endtask

    // Sample n belongs to buffer n / BUF_WORDS at word n % BUF_WORDS
    task automatic feed_samples(input int count);
        int                       gap;
        dma_data_pkg::sample_t    a1;
        dma_data_pkg::sample_t    a2;
        dma_data_pkg::byte_addr_t ea;
        dma_data_pkg::word_t      ed;
        for (int n = 0; n < count; n++) begin
            gap = $urandom_range(0, 2);
            if (gap != 0) begin
                sample_valid_i <= 1'b0;
                repeat (gap) @(posedge clk);
            end
            a1 = dma_data_pkg::sample_t'($urandom_range(0, 4095));
            a2 = dma_data_pkg::sample_t'($urandom_range(0, 4095));
            adc1_i         <= a1;
            adc2_i         <= a2;
            sample_valid_i <= 1'b1;
            do @(negedge clk); while (!sample_ready_o);
            expected_word(posted[n / BUF_WORDS], n % BUF_WORDS, a1, a2, ea, ed);
            exp_addr_q.push_back(ea);
            exp_data_q.push_back(ed);
            @(posedge clk);  // Sample taken
        end
        sample_valid_i <= 1'b0;
    endtask

    // --------------------------------------------------
    // Write port back-pressure, monitor and timeout
    // --------------------------------------------------
    always @(posedge clk) begin
        wr_ready_i <= ($urandom_range(0, 3) != 0);  // Stall about a quarter of cycles
    end

    always @(negedge clk) begin
        if (rst_n && wr_valid_o && wr_ready_i) begin
            if (exp_addr_q.size() == 0) begin
                abort_run("write-port transfer with no word expected");
            end else begin
                check_addr("wr_addr_o", wr_addr_o, exp_addr_q.pop_front());
                check_word("wr_data_o", wr_data_o, exp_data_q.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            abort_run("timeout: run did not finish");
        end
    end

    initial begin
        logic [1:0]          resp;
        dma_data_pkg::word_t rdata;
        dma_data_pkg::word_t exp_status;
        void'($urandom(45428));
        rst_n          <= 1'b0;
        s_awaddr_i     <= '0;
        s_awvalid_i    <= 1'b0;
        s_wdata_i      <= '0;
        s_wvalid_i     <= 1'b0;
        s_bready_i     <= 1'b0;
        s_araddr_i     <= '0;
        s_arvalid_i    <= 1'b0;
        s_rready_i     <= 1'b0;
        adc1_i         <= '0;
        adc2_i         <= '0;
        sample_valid_i <= 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        if (s_bvalid_o || s_rvalid_o || wr_valid_o || sample_ready_o) begin
            abort_run("a valid or ready output was high after reset");
        end
        @(posedge clk);

        // Register access
        expect_read(dma_cfg_pkg::REG_STATUS, '0, dma_cfg_pkg::RESP_OKAY, "status");
        store_ok(dma_cfg_pkg::REG_CTRL, 32'h1, "ctrl");
        expect_read(dma_cfg_pkg::REG_CTRL, 32'h1, dma_cfg_pkg::RESP_OKAY, "ctrl");
        store_ok(dma_cfg_pkg::REG_BUF_LEN, 32'hA5, "buf_len");
        expect_read(dma_cfg_pkg::REG_BUF_LEN, 32'hA5, dma_cfg_pkg::RESP_OKAY, "buf_len");
        store_ok(dma_cfg_pkg::REG_CTRL, 32'h0, "ctrl");

        // Data path under random gaps and back-pressure
        for (int k = 0; k < NUM_BUFS; k++) begin
            posted[k] = dma_data_pkg::byte_addr_t'($urandom) & 32'hFFFF_FF00;
            store_ok(dma_cfg_pkg::REG_BUF_POST, posted[k], "buf_post");
        end
        store_ok(dma_cfg_pkg::REG_BUF_LEN, dma_data_pkg::word_t'(BUF_WORDS), "buf_len");
        store_ok(dma_cfg_pkg::REG_CTRL, 32'h1 << dma_cfg_pkg::CTRL_ENABLE_BIT, "ctrl");
        feed_samples(NUM_BUFS * BUF_WORDS);
        while (exp_addr_q.size() != 0) @(posedge clk);

        // Address recycling
        do begin
            read_reg(dma_cfg_pkg::REG_STATUS, rdata, resp);
        end while (rdata[12:8] != 5'(NUM_BUFS));
        read_reg(dma_cfg_pkg::REG_BUF_DONE, rdata, resp);
        check_resp("buf_done_rresp", resp, dma_cfg_pkg::RESP_OKAY);
        check_count("buf_done", rdata[15:0], dma_data_pkg::count_t'(NUM_BUFS));
        for (int k = 0; k < NUM_BUFS; k++) begin
            read_reg(dma_cfg_pkg::REG_BUF_RETURN, rdata, resp);
            check_resp("buf_return_rresp", resp, dma_cfg_pkg::RESP_OKAY);
            check_addr("buf_return", rdata, posted[k]);
        end
        expect_read(dma_cfg_pkg::REG_BUF_RETURN, '0, dma_cfg_pkg::RESP_SLVERR, "buf_return");

        // Free FIFO overflow with the writer stopped
        store_ok(dma_cfg_pkg::REG_CTRL, 32'h0, "ctrl");
        for (int k = 0; k <= dma_data_pkg::ADDR_FIFO_DEPTH; k++) begin
            write_reg(dma_cfg_pkg::REG_BUF_POST, 32'h2000_0000 + dma_data_pkg::word_t'(k * 256),
                      resp);
            check_resp("buf_post_bresp", resp, (k < dma_data_pkg::ADDR_FIFO_DEPTH)
                       ? dma_cfg_pkg::RESP_OKAY : dma_cfg_pkg::RESP_SLVERR);
        end
        exp_status = '0;
        exp_status[4:0] = 5'(dma_data_pkg::ADDR_FIFO_DEPTH);
        exp_status[dma_cfg_pkg::STATUS_OVERFLOW_BIT] = 1'b1;
        expect_read(dma_cfg_pkg::REG_STATUS, exp_status, dma_cfg_pkg::RESP_OKAY, "status");

        // Soft reset, then samples offered with no buffer posted
        store_ok(dma_cfg_pkg::REG_CTRL, 32'h1 << dma_cfg_pkg::CTRL_SOFT_RST_BIT, "ctrl");
        expect_read(dma_cfg_pkg::REG_STATUS, '0, dma_cfg_pkg::RESP_OKAY, "status");
        expect_read(dma_cfg_pkg::REG_BUF_DONE, '0, dma_cfg_pkg::RESP_OKAY, "buf_done");
        store_ok(dma_cfg_pkg::REG_CTRL, 32'h1 << dma_cfg_pkg::CTRL_ENABLE_BIT, "ctrl");
        sample_valid_i <= 1'b1;
        repeat (50) @(posedge clk);  // Monitor flags any transfer here
        sample_valid_i <= 1'b0;
        @(posedge clk);

        $display("Everything OK");
        $finish;
    end

endmodule
